/* inputMuxPkg.sv */
// shared word and field types, source select enum and system register address codes
package inputMuxPkg;

    // one data word as seen by the core
    typedef logic [31:0] word_t;      // sram data, muldiv register, sysreg word and rDee

    // address field that picks a system register
    typedef logic [2:0] sysRegAdr_t;

    // lowest address bit of the system register field
    localparam int SYSREG_LSB = 27;   // field occupies adr[29:27]

    // field codes below 5 go out on the external bus
    localparam sysRegAdr_t SYSREG_MIP     = 3'd5; // pending interrupts
    localparam sysRegAdr_t SYSREG_MIE     = 3'd6; // interrupt enables
    localparam sysRegAdr_t SYSREG_MSTATUS = 3'd7; // global enable and its saved copy

    // source that feeds rDee in the current cycle
    typedef enum logic [1:0] {
        SRC_SRAM,   // default when nothing else claims the cycle
        SRC_BUS,    // strobed access outside the system registers
        SRC_MULDIV, // multiply/divide result readout
        SRC_SYSREG  // read-only view of mip, mie or mstatus
    } srcSel_t;

    // the three codes that address a system register
    //   5 selects mip
    //   6 selects mie
    //   7 selects mstatus
    // any other code is left to the bus and its own acknowledge

endpackage

/* srcDecode.sv */
// source decode with system register acknowledge and address field extraction
`timescale 1ns/1ps

module srcDecode import inputMuxPkg::*; (
    input  logic       stb,       // bus strobe from the core
    input  word_t      adr,       // full bus address
    input  logic       clrM,      // muldiv control
    input  logic       ceM,       // muldiv control
    output srcSel_t    sel,       // chosen source for this cycle
    output logic       sysRegAck, // same cycle ack for mip, mie and mstatus
    output sysRegAdr_t sysRegAdr  // field handed to the register view
);

    logic isSysReg;  // field hits one of the three system registers
    logic readM;     // muldiv result is being read

    // pull the register field out of the address
    assign sysRegAdr = adr[SYSREG_LSB +: $bits(sysRegAdr_t)];

    // codes 5 to 7 are system registers
    always_comb begin
        isSysReg = 1'b0;
        if (sysRegAdr == SYSREG_MIP ||
            sysRegAdr == SYSREG_MIE ||
            sysRegAdr == SYSREG_MSTATUS) begin
            isSysReg = 1'b1;
        end
    end

    // ack is combinational and needs the strobe
    assign sysRegAck = stb & isSysReg;

    // clrM and ceM together mean the M register is shifted out
    assign readM = clrM & ceM;

    // priority order
    // strobed sysreg beats strobed bus beats muldiv beats sram
    always_comb begin
        if (stb && isSysReg) begin
            sel = SRC_SYSREG;  // internal register, no bus cycle
        end else if (stb) begin
            sel = SRC_BUS;     // external device answers
        end else if (readM) begin
            sel = SRC_MULDIV;  // muldiv result
        end else begin
            sel = SRC_SRAM;    // sram read data otherwise
        end
    end

    // the bus side acks codes 0 to 4 on its own
    // so nothing here looks at those codes beyond steering the mux

    // no state in this block
    // sel and sysRegAck settle in the same cycle as stb and adr
    // so a system register read completes without any wait state

endmodule

/* sysRegView.sv */
// read word assembly for mip, mie and mstatus from the interrupt flag bits
`timescale 1ns/1ps

module sysRegView import inputMuxPkg::*; (
    input  sysRegAdr_t sysRegAdr,   // register field from decode
    input  logic       mie,         // mstatus global interrupt enable
    input  logic       mpie,        // mstatus previous enable
    input  logic       meie,        // external interrupt enable
    input  logic       msie,        // software interrupt enable
    input  logic       mtie,        // timer interrupt enable
    input  logic       mtimeincie,  // time increment interrupt enable
    input  logic       mrinstretie, // retired instruction interrupt enable
    input  logic       meip,        // external interrupt pending
    input  logic       msip,        // software interrupt pending
    input  logic       mtip,        // timer interrupt pending
    input  logic       mtimeincip,  // time increment interrupt pending
    input  logic       mrinstretip, // retired instruction interrupt pending
    output word_t      sysRegWord   // assembled read value
);

    // only bits 17, 16, 12, 11, 7 and 3 can ever be set
    always_comb begin
        sysRegWord = '0;  // unlisted bits read zero
        case (sysRegAdr)
            SYSREG_MIP: begin
                sysRegWord[17] = mrinstretip; // custom pending bit
                sysRegWord[16] = mtimeincip;  // custom pending bit
                sysRegWord[11] = meip;
                sysRegWord[7]  = mtip;
                sysRegWord[3]  = msip;
            end
            SYSREG_MIE: begin
                // enables share the bit positions of the pending flags
                sysRegWord[17] = mrinstretie;
                sysRegWord[16] = mtimeincie;
                sysRegWord[11] = meie;
                sysRegWord[7]  = mtie;
                sysRegWord[3]  = msie;
            end
            SYSREG_MSTATUS: begin
                sysRegWord[12] = 1'b1;  // mpp hardwired to machine mode
                sysRegWord[11] = 1'b1;
                sysRegWord[7]  = mpie;
                sysRegWord[3]  = mie;
            end
            default: begin
                sysRegWord = '0;  // bus codes, value not used
            end
        endcase
    end

    // purely combinational
    // the select block registers the word together with the other sources

endmodule

/* inputSelect.sv */
// four way source mux with zero extension of the bus and the rDee result register
`timescale 1ns/1ps

module inputSelect import inputMuxPkg::*; #(
    parameter int IWIDTH = 32  // external bus width, 1 to 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              coreRunning, // load enable, low stalls rDee
    input  srcSel_t           sel,         // source from decode
    input  logic [IWIDTH-1:0] datI,        // external data bus
    input  word_t             sramData,    // sram read data
    input  word_t             mulDivReg,   // muldiv result register
    input  word_t             sysRegWord,  // mip, mie or mstatus view
    output word_t             rDee         // registered result
);

    word_t busWord;  // datI widened to a full word
    word_t nextDee;  // mux output ahead of the register

    // narrow bus gets zeros on top
    assign busWord = word_t'(datI);

    // no assumption about datI when idle
    // so each source gets its own full leg
    always_comb begin
        case (sel)
            SRC_BUS: begin
                nextDee = busWord;
            end
            SRC_MULDIV: begin
                nextDee = mulDivReg;
            end
            SRC_SYSREG: begin
                nextDee = sysRegWord;  // unused bits already zero
            end
            default: begin
                nextDee = sramData;    // SRC_SRAM
            end
        endcase
    end

    // one cycle latency
    // the word is captured only while the core runs
    always_ff @(posedge clk) begin
        if (reset) begin
            rDee <= '0;
        end else if (coreRunning) begin
            rDee <= nextDee;
        end
        // otherwise hold, this is the stall path
    end

    // rDee feeds the core datapath directly
    // so the register is the only timing stage of the whole input mux

endmodule

/* inputMux.sv */
// top level of the input mux with decode, system register view and select
`timescale 1ns/1ps

module inputMux import inputMuxPkg::*; #(
    parameter int IWIDTH = 32  // external bus width, passed to the select block
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              stb,         // bus strobe
    input  word_t             adr,         // bus address
    input  logic              clrM,        // muldiv readout control
    input  logic              ceM,         // muldiv readout control
    input  logic              coreRunning, // rDee loads only while high
    input  logic [IWIDTH-1:0] datI,        // external data in
    input  word_t             sramData,    // sram read data
    input  word_t             mulDivReg,   // muldiv result
    input  logic              mie,         // mstatus
    input  logic              mpie,        // mstatus
    input  logic              meie,
    input  logic              msie,
    input  logic              mtie,
    input  logic              mtimeincie,
    input  logic              mrinstretie,
    input  logic              meip,
    input  logic              msip,
    input  logic              mtip,
    input  logic              mtimeincip,
    input  logic              mrinstretip,
    output word_t             rDee,        // registered input word
    output logic              sysRegAck    // combinational sysreg ack
);

    srcSel_t    sel;         // chosen source
    sysRegAdr_t sysRegAdr;   // register field
    word_t      sysRegWord;  // assembled register view

    // address and strobe are examined only here
    srcDecode u_srcDecode (
        .stb       (stb),
        .adr       (adr),
        .clrM      (clrM),
        .ceM       (ceM),
        .sel       (sel),
        .sysRegAck (sysRegAck),
        .sysRegAdr (sysRegAdr)
    );

    sysRegView u_sysRegView (
        .sysRegAdr   (sysRegAdr),
        .mie         (mie),
        .mpie        (mpie),
        .meie        (meie),
        .msie        (msie),
        .mtie        (mtie),
        .mtimeincie  (mtimeincie),
        .mrinstretie (mrinstretie),
        .meip        (meip),
        .msip        (msip),
        .mtip        (mtip),
        .mtimeincip  (mtimeincip),
        .mrinstretip (mrinstretip),
        .sysRegWord  (sysRegWord)
    );

    // mux and result register
    inputSelect #(
        .IWIDTH (IWIDTH)
    ) u_inputSelect (
        .clk         (clk),
        .reset       (reset),
        .coreRunning (coreRunning),
        .sel         (sel),
        .datI        (datI),
        .sramData    (sramData),
        .mulDivReg   (mulDivReg),
        .sysRegWord  (sysRegWord),
        .rDee        (rDee)
    );

endmodule

/* inputMux_assert.sv */
// concurrent checks on the system register ack and on rDee hold, bound into the top level
`timescale 1ns/1ps

module inputMux_assert import inputMuxPkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  stb,
    input word_t adr,
    input logic  coreRunning,
    input word_t rDee,
    input logic  sysRegAck
);

    int failCount = 0;  // failed assertion attempts so far

    // ack only answers a strobe, reset included
    ackNeedsStb: assert property (@(posedge clk) sysRegAck |-> stb)
        else begin
            failCount++;
            $error("sysRegAck high without stb");
        end

    // codes 0 to 4 belong to the external bus
    ackNeedsSysRegCode: assert property (
        @(posedge clk) sysRegAck |-> (adr[SYSREG_LSB +: 3] >= SYSREG_MIP)
    ) else begin
        failCount++;
        $error("sysRegAck high for a bus address code");
    end

    // a stalled cycle must not move the result register
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (reset)
        !coreRunning |=> $stable(rDee)
    ) else begin
        failCount++;
        $error("rDee changed after a stalled cycle");
    end

endmodule

bind inputMux inputMux_assert u_inputMuxAssert (
    .clk         (clk),
    .reset       (reset),
    .stb         (stb),
    .adr         (adr),
    .coreRunning (coreRunning),
    .rDee        (rDee),
    .sysRegAck   (sysRegAck)
);

/* inputMuxTb.sv */
// testbench for the input mux with random stimulus, reference model, checks and watchdog
`timescale 1ns/1ps

module inputMuxTb import inputMuxPkg::*; ();

    localparam int IWIDTH       = 16;   // narrow bus so zero extension shows up
    localparam int CLK_PERIOD   = 4;    // ns
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 2000; // random cycles after reset
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD + 400;

    logic              clk;
    logic              reset;
    logic              stb;
    word_t             adr;
    logic              clrM;
    logic              ceM;
    logic              coreRunning;
    logic [IWIDTH-1:0] datI;
    word_t             sramData;
    word_t             mulDivReg;
    logic              mie, mpie, meie, msie, mtie, mtimeincie, mrinstretie;
    logic              meip, msip, mtip, mtimeincip, mrinstretip;
    word_t             rDee;
    logic              sysRegAck;

    int    seed = 32'h51fe_f30f;  // fixed seed for $random
    int    cyc;
    word_t expDee;                 // model of rDee
    bit    expValid;               // model known once reset was sampled
    int    errCount;
    int    checkCount;
    int    assertFails;            // failures of the bound concurrent checks
    int    busReads, sysRegReads, mulReads, sramReads, stallCycles;

    inputMux #(
        .IWIDTH (IWIDTH)
    ) i_inputMux (
        .clk (clk), .reset (reset), .stb (stb), .adr (adr),
        .clrM (clrM), .ceM (ceM), .coreRunning (coreRunning), .datI (datI),
        .sramData (sramData), .mulDivReg (mulDivReg),
        .mie (mie), .mpie (mpie), .meie (meie), .msie (msie), .mtie (mtie),
        .mtimeincie (mtimeincie), .mrinstretie (mrinstretie),
        .meip (meip), .msip (msip), .mtip (mtip),
        .mtimeincip (mtimeincip), .mrinstretip (mrinstretip),
        .rDee (rDee), .sysRegAck (sysRegAck)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // register view straight from the bit layout table
    function automatic word_t expSysReg(input sysRegAdr_t code);
        word_t w;
        w = '0;
        if (code == SYSREG_MIP) begin
            w = (word_t'(mrinstretip) << 17) | (word_t'(mtimeincip) << 16)
              | (word_t'(meip) << 11) | (word_t'(mtip) << 7) | (word_t'(msip) << 3);
        end else if (code == SYSREG_MIE) begin
            w = (word_t'(mrinstretie) << 17) | (word_t'(mtimeincie) << 16)
              | (word_t'(meie) << 11) | (word_t'(mtie) << 7) | (word_t'(msie) << 3);
        end else if (code == SYSREG_MSTATUS) begin
            w = 32'h0000_1800 | (word_t'(mpie) << 7) | (word_t'(mie) << 3);
        end
        return w;
    endfunction

    // called right at the edge, so inputs still hold what the DUT samples
    task automatic updateModel();
        sysRegAdr_t code;
        code = adr[SYSREG_LSB +: 3];
        if (reset) begin
            expDee   = '0;
            expValid = 1'b1;
        end else if (!coreRunning) begin
            stallCycles++;                  // expDee holds
        end else if (stb && code >= SYSREG_MIP) begin
            expDee = expSysReg(code);
            sysRegReads++;
        end else if (stb) begin
            expDee = {{(32 - IWIDTH){1'b0}}, datI};  // upper bits zero
            busReads++;
        end else if (clrM && ceM) begin
            expDee = mulDivReg;
            mulReads++;
        end else begin
            expDee = sramData;
            sramReads++;
        end
    endtask

    // new random inputs for the next cycle
    task automatic driveRandom(input bit allowStb);
        word_t r;
        word_t a;
        int    pick;
        r = $random(seed);
        a = $random(seed);
        if (r[20]) begin
            pick = {$random(seed)} % 3;     // half of all addresses hit 5 to 7
            a[SYSREG_LSB +: 3] = SYSREG_MIP + 3'(pick);
        end
        stb         <= allowStb & r[0];
        clrM        <= r[1];
        ceM         <= r[2];
        coreRunning <= (r[5:3] != 3'd0);    // stalls about one cycle in eight
        {mrinstretip, mtimeincip, mtip, msip, meip, mrinstretie,
         mtimeincie, mtie, msie, meie, mpie, mie} <= r[19:8];
        adr       <= a;
        datI      <= r[31:32 - IWIDTH];
        sramData  <= $random(seed);
        mulDivReg <= $random(seed);
    endtask

    task automatic checkOutputs();
        logic expAck;
        expAck = stb && (adr[SYSREG_LSB +: 3] >= SYSREG_MIP);  // combinational ack
        checkCount++;
        assert (sysRegAck === expAck) else begin
            errCount++;
            $display("ERR %0t sysRegAck expected %b actual %b", $time, expAck, sysRegAck);
        end
        if (expValid) begin
            checkCount++;
            assert (rDee === expDee) else begin
                errCount++;
                $display("ERR %0t rDee expected %h actual %h", $time, expDee, rDee);
            end
        end
    endtask

    task automatic requireSeen(input int count, input string what);
        assert (count > 0) else begin
            errCount++;
            $display("no %s happened during the random run", what);
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        stb         = 1'b0;
        adr         = '0;
        clrM        = 1'b0;
        ceM         = 1'b0;
        coreRunning = 1'b0;
        datI        = '0;
        sramData    = '0;
        mulDivReg   = '0;
        {mrinstretip, mtimeincip, mtip, msip, meip, mrinstretie,
         mtimeincie, mtie, msie, meie, mpie, mie} = '0;
        expValid    = 1'b0;
        for (cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
            @(posedge clk);
            updateModel();
            if (cyc >= RESET_CYCLES - 1) begin
                reset <= 1'b0;              // dut saw reset on five edges
            end
            driveRandom(cyc >= RESET_CYCLES - 1);  // stb stays low in reset
            @(negedge clk);
            checkOutputs();
        end
        requireSeen(busReads, "bus read");
        requireSeen(sysRegReads, "system register read");
        requireSeen(mulReads, "muldiv read");
        requireSeen(sramReads, "sram read");
        requireSeen(stallCycles, "stall");
        assertFails = i_inputMux.u_inputMuxAssert.failCount;
        $display("checks %0d errors %0d assert %0d bus %0d sys %0d mul %0d sram %0d stall %0d",
                 checkCount, errCount, assertFails, busReads, sysRegReads, mulReads,
                 sramReads, stallCycles);
        if (errCount == 0 && assertFails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog timeout, the random run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* project.f */
inputMuxPkg.sv
srcDecode.sv
sysRegView.sv
inputSelect.sv
inputMux.sv
inputMux_assert.sv
inputMuxTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := inputMuxTb
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
